//--- src/chess_consts.svh
`ifndef CHESS_CONSTS_SVH
`define CHESS_CONSTS_SVH

`define PIECE_BITS 4
`define BLACK_BIT  3

`define EMPTY_POSN 0
`define PIECE_PAWN 1
`define PIECE_KNIT 2
`define PIECE_BISH 3
`define PIECE_ROOK 4
`define PIECE_QUEN 5
`define PIECE_KING 6

`define MAX_MOVES 128

// (row step, column step) per entry, row 0 is white's home rank
`define QUEEN_DR '{-1, -1, -1,  0,  0,  1,  1,  1}
`define QUEEN_DC '{-1,  0,  1, -1,  1, -1,  0,  1}

`define ROOK_DR  '{ 0,  0,  1, -1}
`define ROOK_DC  '{ 1, -1,  0,  0}

`define BISH_DR  '{ 1,  1, -1, -1}
`define BISH_DC  '{ 1, -1,  1, -1}

`define KNIT_DR  '{-2, -1,  1,  2,  2,  1, -1, -2}
`define KNIT_DC  '{-1, -2, -2, -1,  1,  2,  2,  1}

`endif

//--- src/chess_pkg.sv
`include "chess_consts.svh"

package chess_pkg;

   // one square of the board
   typedef logic [`PIECE_BITS-1:0] piece_t;

   // signed, so off-board steps fall outside 0..7
   typedef logic signed [4:0] coord_t;

   // square index, row * 8 + column
   typedef logic [5:0] sq_t;

   typedef piece_t [63:0] board_t;

   typedef logic [$clog2(`MAX_MOVES)-1:0] move_idx_t;

   // one piece handed from decode to execute
   typedef struct packed
   {
      logic       valid;
      piece_t     piece;
      logic [2:0] row;
      logic [2:0] col;
   } piece_req_t;

   // one entry of the move memory
   typedef struct packed
   {
      board_t board;
      logic   capture;
   } move_rec_t;

endpackage

//--- src/square_decode.sv
`timescale 1ns/1ps
`include "chess_consts.svh"

module square_decode
  (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  board_valid,
   input  chess_pkg::board_t     board_in,
   input  logic                  white_to_move_in,
   input  logic                  clear_moves,
   input  logic                  piece_done,
   output chess_pkg::board_t     board,
   output logic                  white_to_move,
   output chess_pkg::piece_req_t req,
   output logic                  scan_start,
   output logic                  moves_ready
   );

   import chess_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_SCAN, S_WAIT, S_DONE} state_t;

   state_t state;
   sq_t    sq;
   piece_t sq_piece;
   logic   is_mover;
   logic   last_sq;

   assign sq_piece = board[sq];
   assign is_mover = (sq_piece != `EMPTY_POSN) &&
                     (sq_piece[`BLACK_BIT] == !white_to_move);
   assign last_sq  = (sq == 6'd63);

   always_ff @(posedge clk)
   begin
      if (state == S_IDLE && board_valid)
      begin
         board         <= board_in;
         white_to_move <= white_to_move_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= S_IDLE;
         sq          <= '0;
         req.valid   <= 1'b0;
         scan_start  <= 1'b0;
         moves_ready <= 1'b0;
      end
      else
      begin
         req.valid  <= 1'b0;
         scan_start <= 1'b0;
         case (state)
            S_IDLE:
            begin
               sq <= '0;
               if (board_valid)
               begin
                  scan_start <= 1'b1; // clears the store count
                  state      <= S_SCAN;
               end
            end
            S_SCAN:
            begin
               req.piece <= sq_piece;
               req.row   <= sq[5:3];
               req.col   <= sq[2:0];
               if (is_mover)
               begin
                  req.valid <= 1'b1;
                  state     <= S_WAIT;
               end
               else if (last_sq)
               begin
                  moves_ready <= 1'b1;
                  state       <= S_DONE;
               end
               else
                  sq <= sq + 6'd1; // empty or opponent, one cycle
            end
            S_WAIT:
            begin
               if (piece_done && last_sq)
               begin
                  moves_ready <= 1'b1;
                  state       <= S_DONE;
               end
               else if (piece_done)
               begin
                  sq    <= sq + 6'd1;
                  state <= S_SCAN;
               end
            end
            S_DONE:
            begin
               if (clear_moves)
               begin
                  moves_ready <= 1'b0;
                  state       <= S_IDLE;
               end
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- src/move_execute.sv
`timescale 1ns/1ps
`include "chess_consts.svh"

module move_execute
  (
   input  logic                  clk,
   input  logic                  reset,
   input  chess_pkg::board_t     board,
   input  logic                  white_to_move,
   input  chess_pkg::piece_req_t req,
   output chess_pkg::move_rec_t  wr,
   output logic                  wr_en,
   output logic                  piece_done
   );

   import chess_pkg::*;

   localparam logic signed [2:0] queen_dr [0:7] = `QUEEN_DR;
   localparam logic signed [2:0] queen_dc [0:7] = `QUEEN_DC;
   localparam logic signed [2:0] rook_dr [0:3]  = `ROOK_DR;
   localparam logic signed [2:0] rook_dc [0:3]  = `ROOK_DC;
   localparam logic signed [2:0] bish_dr [0:3]  = `BISH_DR;
   localparam logic signed [2:0] bish_dc [0:3]  = `BISH_DC;
   localparam logic signed [2:0] knit_dr [0:7]  = `KNIT_DR;
   localparam logic signed [2:0] knit_dc [0:7]  = `KNIT_DC;

   typedef enum logic [1:0] {E_IDLE, E_WALK, E_PAWN} state_t;

   state_t     state;
   piece_t     piece;
   logic [2:0] ptype;
   coord_t     src_row;
   coord_t     src_col;
   coord_t     cur_row;
   coord_t     cur_col;
   logic [2:0] dir_idx;
   logic [2:0] next_dir;
   logic [1:0] pawn_step;

   coord_t     fwd;
   coord_t     home_row;
   coord_t     mid_row;
   coord_t     tgt_row;
   coord_t     tgt_col;
   sq_t        src_sq;
   sq_t        tgt_sq;
   sq_t        mid_sq;
   piece_t     tgt_piece;
   logic       on_board;
   logic       tgt_empty;
   logic       tgt_opp;
   logic       mid_empty;
   logic       slides;
   logic       keep_going;
   logic       last_dir;
   logic       walk_ok;
   logic       pawn_ok;
   board_t     next_board;

   // king shares the queen table, one step only
   function automatic coord_t dir_row(input logic [2:0] kind, input logic [2:0] i);
      case (kind)
         `PIECE_ROOK: return rook_dr[i[1:0]];
         `PIECE_BISH: return bish_dr[i[1:0]];
         `PIECE_KNIT: return knit_dr[i];
         default:     return queen_dr[i];
      endcase
   endfunction

   function automatic coord_t dir_col(input logic [2:0] kind, input logic [2:0] i);
      case (kind)
         `PIECE_ROOK: return rook_dc[i[1:0]];
         `PIECE_BISH: return bish_dc[i[1:0]];
         `PIECE_KNIT: return knit_dc[i];
         default:     return queen_dc[i];
      endcase
   endfunction

   assign ptype    = piece[2:0];
   assign next_dir = dir_idx + 3'd1;
   assign fwd      = white_to_move ? 5'sd1 : -5'sd1;
   assign home_row = white_to_move ? 5'sd1 : 5'sd6;
   assign mid_row  = src_row + fwd;

   assign slides   = (ptype == `PIECE_QUEN) || (ptype == `PIECE_ROOK) ||
                     (ptype == `PIECE_BISH);
   assign last_dir = ((ptype == `PIECE_ROOK) || (ptype == `PIECE_BISH)) ?
                     (dir_idx == 3'd3) : (dir_idx == 3'd7);

   // pawn targets follow the step, walkers use the running square
   always_comb
   begin
      tgt_row = cur_row;
      tgt_col = cur_col;
      if (state == E_PAWN)
      begin
         tgt_row = mid_row;
         tgt_col = src_col;
         case (pawn_step)
            2'd0: tgt_row = mid_row + fwd; // double advance
            2'd1: tgt_col = src_col - 5'sd1;
            2'd2: tgt_col = src_col;
            2'd3: tgt_col = src_col + 5'sd1;
         endcase
      end
   end

   assign on_board  = (tgt_row >= 0) && (tgt_row <= 7) && (tgt_col >= 0) && (tgt_col <= 7);
   assign src_sq    = {src_row[2:0], src_col[2:0]};
   assign tgt_sq    = {tgt_row[2:0], tgt_col[2:0]};
   assign mid_sq    = {mid_row[2:0], src_col[2:0]};
   assign tgt_piece = board[tgt_sq];
   assign tgt_empty = (tgt_piece == `EMPTY_POSN);
   assign tgt_opp   = !tgt_empty && (tgt_piece[`BLACK_BIT] == white_to_move);
   assign mid_empty = (board[mid_sq] == `EMPTY_POSN);

   assign keep_going = slides && on_board && tgt_empty;
   assign walk_ok    = on_board && (tgt_empty || tgt_opp);
   assign pawn_ok    = on_board &&
                       ((pawn_step == 2'd0) ? (src_row == home_row) && mid_empty && tgt_empty :
                        (pawn_step == 2'd2) ? tgt_empty : tgt_opp);

   always_comb
   begin
      next_board         = board;
      next_board[src_sq] = piece_t'(`EMPTY_POSN);
      next_board[tgt_sq] = piece;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= E_IDLE;
         wr_en      <= 1'b0;
         piece_done <= 1'b0;
      end
      else
      begin
         wr_en      <= 1'b0;
         piece_done <= 1'b0;
         case (state)
            E_IDLE:
            begin
               if (req.valid && req.piece[2:0] == `PIECE_PAWN)
                  state <= E_PAWN;
               else if (req.valid)
                  state <= E_WALK;
            end
            E_WALK:
            begin
               wr_en <= walk_ok;
               if (!keep_going && last_dir)
               begin
                  piece_done <= 1'b1; // same cycle as the last write
                  state      <= E_IDLE;
               end
            end
            E_PAWN:
            begin
               wr_en <= pawn_ok;
               if (pawn_step == 2'd3)
               begin
                  piece_done <= 1'b1;
                  state      <= E_IDLE;
               end
            end
            default:
               state <= E_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      wr.board   <= next_board;
      wr.capture <= tgt_opp;
      case (state)
         E_IDLE:
         begin
            piece     <= req.piece;
            src_row   <= coord_t'({2'b00, req.row});
            src_col   <= coord_t'({2'b00, req.col});
            cur_row   <= coord_t'({2'b00, req.row}) + dir_row(req.piece[2:0], 3'd0);
            cur_col   <= coord_t'({2'b00, req.col}) + dir_col(req.piece[2:0], 3'd0);
            dir_idx   <= '0;
            pawn_step <= '0;
         end
         E_WALK:
         begin
            if (keep_going)
            begin
               cur_row <= cur_row + dir_row(ptype, dir_idx);
               cur_col <= cur_col + dir_col(ptype, dir_idx);
            end
            else
            begin
               dir_idx <= next_dir; // restart from the source square
               cur_row <= src_row + dir_row(ptype, next_dir);
               cur_col <= src_col + dir_col(ptype, next_dir);
            end
         end
         default:
            pawn_step <= pawn_step + 2'd1;
      endcase
   end

endmodule

//--- src/move_store.sv
`timescale 1ns/1ps
`include "chess_consts.svh"

module move_store
  (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  scan_start,
   input  chess_pkg::move_rec_t                  wr,
   input  logic                                  wr_en,
   input  chess_pkg::move_idx_t                  move_index,
   output logic [$bits(chess_pkg::move_idx_t):0] move_count,
   output chess_pkg::board_t                     board_out,
   output logic                                  capture_out,
   output logic                                  move_ready
   );

   import chess_pkg::*;

   typedef logic [$bits(move_idx_t):0] count_t;

   move_rec_t mem [0:`MAX_MOVES-1];
   move_rec_t rd_data;
   move_idx_t index_q;
   logic      mem_full;

   assign mem_full    = (move_count == `MAX_MOVES); // count saturates here
   assign board_out   = rd_data.board;
   assign capture_out = rd_data.capture;

   always_ff @(posedge clk)
   begin
      if (reset || scan_start)
         move_count <= '0;
      else if (wr_en && !mem_full)
         move_count <= move_count + count_t'(1);
   end

   always_ff @(posedge clk)
   begin
      if (wr_en && !mem_full)
         mem[move_idx_t'(move_count)] <= wr;
      rd_data <= mem[move_index];
   end

   // index held for two samples
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         index_q    <= '0;
         move_ready <= 1'b0;
      end
      else
      begin
         index_q    <= move_index;
         move_ready <= (move_index == index_q);
      end
   end

endmodule

//--- src/move_gen_top.sv
`timescale 1ns/1ps

module move_gen_top
  (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  board_valid,
   input  chess_pkg::board_t                     board_in,
   input  logic                                  white_to_move_in,
   input  logic                                  clear_moves,
   input  chess_pkg::move_idx_t                  move_index,
   output logic [$bits(chess_pkg::move_idx_t):0] move_count,
   output chess_pkg::board_t                     board_out,
   output logic                                  capture_out,
   output logic                                  moves_ready,
   output logic                                  move_ready
   );

   import chess_pkg::*;

   board_t     board;
   logic       white_to_move;
   piece_req_t req;
   logic       scan_start;
   logic       piece_done;
   move_rec_t  wr;
   logic       wr_en;

   square_decode u_decode
     (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .piece_done       (piece_done),
      .board            (board),
      .white_to_move    (white_to_move),
      .req              (req),
      .scan_start       (scan_start),
      .moves_ready      (moves_ready)
      );

   move_execute u_execute
     (
      .clk           (clk),
      .reset         (reset),
      .board         (board),
      .white_to_move (white_to_move),
      .req           (req),
      .wr            (wr),
      .wr_en         (wr_en),
      .piece_done    (piece_done)
      );

   move_store u_store
     (
      .clk         (clk),
      .reset       (reset),
      .scan_start  (scan_start),
      .wr          (wr),
      .wr_en       (wr_en),
      .move_index  (move_index),
      .move_count  (move_count),
      .board_out   (board_out),
      .capture_out (capture_out),
      .move_ready  (move_ready)
      );

endmodule

//--- sim/move_checker.sv
`timescale 1ns/1ps

module move_checker
  (
   input  logic                 clk,
   input  logic                 check_start,
   input  logic [127:0]         test_name,
   input  logic [7:0]           exp_count,
   input  chess_pkg::move_rec_t exp_rec,
   input  logic                 moves_ready,
   input  logic [7:0]           move_count,
   input  chess_pkg::board_t    board_out,
   input  logic                 capture_out,
   input  logic                 move_ready,
   output chess_pkg::move_idx_t move_index,
   output logic                 clear_moves,
   output logic                 check_done,
   output int                   passes,
   output int                   fails
   );

   import chess_pkg::*;

   int        errs;
   int        n;
   int        i;
   move_idx_t prev_index;

   // reads back every stored move once the scan is over
   task automatic check_moves();
      errs = 0;
      @(negedge clk);
      while (!moves_ready)
         @(negedge clk);
      if (move_count !== exp_count)
      begin
         $display("Error %0s: move_count expected %0d actual %0d",
                  test_name, exp_count, move_count);
         errs++;
      end
      n = (move_count < exp_count) ? move_count : exp_count;
      for (i = 0; i < n; i++)
      begin
         prev_index = move_index;
         move_index = move_idx_t'(i);
         @(negedge clk);
         if (move_index != prev_index && move_ready !== 1'b0)
         begin
            $display("Error %0s: move %0d move_ready after index change expected 0 actual %b",
                     test_name, i, move_ready);
            errs++;
         end
         while (!move_ready) // read port settles after the index holds
            @(negedge clk);
         if (board_out !== exp_rec.board)
         begin
            $display("Error %0s: move %0d board expected %h actual %h",
                     test_name, i, exp_rec.board, board_out);
            errs++;
         end
         if (capture_out !== exp_rec.capture)
         begin
            $display("Error %0s: move %0d capture expected %0b actual %0b",
                     test_name, i, exp_rec.capture, capture_out);
            errs++;
         end
      end
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      if (moves_ready !== 1'b0)
      begin
         $display("Error %0s: moves_ready after clear_moves expected 0 actual %b",
                  test_name, moves_ready);
         errs++;
      end
   endtask

   initial
   begin
      move_index  = '0;
      clear_moves = 1'b0;
      check_done  = 1'b0;
      passes      = 0;
      fails       = 0;
      forever
      begin
         wait (check_start);
         check_moves();
         if (errs == 0)
         begin
            passes++;
            $display("%0s: pass, %0d moves", test_name, exp_count);
         end
         else
         begin
            fails++;
            $display("%0s: fail, %0d mismatches", test_name, errs);
         end
         check_done = 1'b1;
         wait (!check_start);
         check_done = 1'b0;
      end
   end

endmodule

//--- sim/tb_move_gen.sv
`timescale 1ns/1ps
`include "chess_consts.svh"

module tb_move_gen;

   import chess_pkg::*;

   localparam int num_tests = 26;

   localparam int queen_r [0:7] = `QUEEN_DR;
   localparam int queen_c [0:7] = `QUEEN_DC;
   localparam int rook_r [0:3]  = `ROOK_DR;
   localparam int rook_c [0:3]  = `ROOK_DC;
   localparam int bish_r [0:3]  = `BISH_DR;
   localparam int bish_c [0:3]  = `BISH_DC;
   localparam int knit_r [0:7]  = `KNIT_DR;
   localparam int knit_c [0:7]  = `KNIT_DC;

   // square 63 is the leftmost nibble
   localparam board_t start_pos =
      256'hCABEDBAC_99999999_00000000_00000000_00000000_00000000_11111111_42365324;
   localparam board_t slider_pos =
      256'h00C0000E_0A000000_00500000_00000000_09004020_00000000_00000030_00060000;
   localparam board_t black_pos =
      256'hA000000E_00909009_00421000_90000000_03000000_00000000_00000000_00060000;
   localparam board_t lone_king =
      256'h000E0000_00000000_00000000_00000000_00000000_00000000_00000000_00000000;

   logic         clk;
   logic         reset;
   logic         board_valid;
   board_t       board_in;
   logic         white_to_move_in;
   logic         clear_moves;
   move_idx_t    move_index;
   logic [7:0]   move_count;
   board_t       board_out;
   logic         capture_out;
   logic         moves_ready;
   logic         move_ready;

   move_rec_t    exp_list [0:`MAX_MOVES-1];
   move_rec_t    exp_rec;
   logic [7:0]   exp_count;
   logic [127:0] test_name;
   logic [127:0] rand_name;
   logic         check_start;
   logic         check_done;
   int           passes;
   int           fails;
   int           reset_fails;
   logic [31:0]  rng;
   board_t       rand_b;
   logic         rand_wtm;
   int           i;

   assign exp_rec = exp_list[move_index]; // expected entry for the index being read

   move_gen_top DUT (.*);

   move_checker u_checker (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic is_opp(input piece_t t, input logic wtm);
      return (t != `EMPTY_POSN) && (t[`BLACK_BIT] == wtm);
   endfunction

   function automatic void table_step(input logic [2:0] kind, input int i, output int dr,
                                      output int dc);
      dr = (kind == `PIECE_KNIT) ? knit_r[i] : (kind == `PIECE_ROOK) ? rook_r[i % 4] :
           (kind == `PIECE_BISH) ? bish_r[i % 4] : queen_r[i];
      dc = (kind == `PIECE_KNIT) ? knit_c[i] : (kind == `PIECE_ROOK) ? rook_c[i % 4] :
           (kind == `PIECE_BISH) ? bish_c[i % 4] : queen_c[i];
   endfunction

   function automatic void add_move(input board_t b, input int from, input int to, inout int n);
      move_rec_t rec;
      rec.board       = b;
      rec.capture     = (b[to] != `EMPTY_POSN);
      rec.board[to]   = b[from];
      rec.board[from] = '0;
      if (n < `MAX_MOVES)
      begin
         exp_list[n] = rec;
         n++;
      end
   endfunction

   function automatic int ref_moves(input board_t b, input logic wtm);
      int     n, sq, r, c, d, nd;
      int     dr, dc, tr, tc, fwd;
      logic   slide;
      logic   stop;
      piece_t p;
      n   = 0;
      fwd = wtm ? 1 : -1;
      for (sq = 0; sq < 64; sq++)
      begin
         p = b[sq];
         r = sq / 8;
         c = sq % 8;
         if (p == `EMPTY_POSN || p[`BLACK_BIT] == wtm)
            continue;
         if (p[2:0] == `PIECE_PAWN)
         begin
            tr = r + fwd;
            if (r == (wtm ? 1 : 6) && b[tr*8+c] == `EMPTY_POSN && b[(tr+fwd)*8+c] == `EMPTY_POSN)
               add_move(b, sq, (tr + fwd) * 8 + c, n);
            for (d = -1; d <= 1; d++) // left capture, advance, right capture
            begin
               tc = c + d;
               if (tr < 0 || tr > 7 || tc < 0 || tc > 7)
                  continue;
               if (d == 0 ? b[tr*8+tc] == `EMPTY_POSN : is_opp(b[tr*8+tc], wtm))
                  add_move(b, sq, tr * 8 + tc, n);
            end
            continue;
         end
         slide = (p[2:0] == `PIECE_QUEN) || (p[2:0] == `PIECE_ROOK) || (p[2:0] == `PIECE_BISH);
         nd    = ((p[2:0] == `PIECE_ROOK) || (p[2:0] == `PIECE_BISH)) ? 4 : 8;
         for (d = 0; d < nd; d++)
         begin
            table_step(p[2:0], d, dr, dc);
            tr   = r + dr;
            tc   = c + dc;
            stop = 1'b0;
            while (!stop && tr >= 0 && tr <= 7 && tc >= 0 && tc <= 7)
            begin
               if (b[tr*8+tc] == `EMPTY_POSN || is_opp(b[tr*8+tc], wtm))
                  add_move(b, sq, tr * 8 + tc, n);
               stop = !slide || (b[tr*8+tc] != `EMPTY_POSN);
               tr   = tr + dr;
               tc   = tc + dc;
            end
         end
      end
      return n;
   endfunction

   // up to 8 pieces of codes 1..6 in either colour
   task automatic random_board(output board_t b, output logic wtm);
      int k;
      int cnt;
      b   = '0;
      rng = xorshift(rng);
      cnt = 1 + int'(rng % 8);
      wtm = rng[16];
      for (k = 0; k < cnt; k++)
      begin
         rng         = xorshift(rng);
         b[rng[5:0]] = {rng[20], 3'(1 + rng[15:8] % 6)};
      end
   endtask

   task automatic run_test(input logic [127:0] name, input board_t b, input logic wtm);
      exp_count = 8'(ref_moves(b, wtm));
      test_name = name;
      @(negedge clk);
      board_in         = b;
      white_to_move_in = wtm;
      board_valid      = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      check_start = 1'b1;
      wait (check_done);
      check_start = 1'b0;
      wait (!check_done);
   endtask

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   initial
   begin
      repeat (num_tests * 5000) @(posedge clk);
      $display("run hung, no result after %0d clock cycles", num_tests * 5000);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b1;
      check_start      = 1'b0;
      test_name        = '0;
      exp_count        = '0;
      reset_fails      = 0;
      rng              = 32'hf5a5;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if (moves_ready !== 1'b0)
      begin
         $display("Error reset_state: moves_ready expected 0 actual %b", moves_ready);
         reset_fails = 1;
      end
      if (move_count !== 8'd0)
      begin
         $display("Error reset_state: move_count expected 0 actual %0d", move_count);
         reset_fails = 1;
      end
      if (reset_fails == 0)
         $display("reset_state: pass");
      else
         $display("reset_state: fail");
      run_test("start_white", start_pos, 1'b1);
      run_test("slider_stops", slider_pos, 1'b1);
      run_test("black_pawns", black_pos, 1'b0);
      run_test("no_mover", lone_king, 1'b1);
      for (i = 0; i < 20; i++)
      begin
         random_board(rand_b, rand_wtm);
         $sformat(rand_name, "random_%0d", i);
         run_test(rand_name, rand_b, rand_wtm);
      end
      run_test("restart_black", start_pos, 1'b0); // fresh count after clear
      $display("tests passed %0d, failed %0d", passes + 1 - reset_fails, fails + reset_fails);
      if (fails == 0 && reset_fails == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- compile.f
+incdir+src
src/chess_pkg.sv
src/square_decode.sv
src/move_execute.sv
src/move_store.sv
src/move_gen_top.sv
sim/move_checker.sv
sim/tb_move_gen.sv

//--- Makefile
TOP = tb_move_gen

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f compile.f --top-module move_gen_top

clean:
	rm -rf obj_dir sim.log
